//--- ooo_defs.svh
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

// Datapath and immediate width
`define OOO_XLEN      32

// Instruction address width
`define OOO_PC_W      9

// Architectural register index, x0..x31
`define OOO_AREG_W    5

// Physical register index and count
`define OOO_PREG_W    7
`define OOO_NUM_PREGS 128

// Reorder buffer size and tag width
`define OOO_ROB_DEPTH 16
`define OOO_ROB_W     4

`endif

//--- ooo_pkg.sv
`include "ooo_defs.svh"

package ooo_pkg;

  // RV32I major opcodes seen by decode
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // Target unit, routed by the consumer of the issue port
  typedef enum logic [1:0] {
    FU_ALU    = 2'd0,
    FU_BRANCH = 2'd1,
    FU_LSU    = 2'd2
  } fu_type_e;

  // ALU operation class
  typedef enum logic [1:0] {
    ALUOP_ADD    = 2'b00,  // address add for loads and stores
    ALUOP_BRANCH = 2'b01,
    ALUOP_FUNCT  = 2'b10,
    ALUOP_IMM    = 2'b11
  } alu_op_e;

  // Decode -> rename payload
  typedef struct packed {
    logic [`OOO_PC_W-1:0]   pc;
    logic [`OOO_AREG_W-1:0] rs1;
    logic [`OOO_AREG_W-1:0] rs2;
    logic [`OOO_AREG_W-1:0] rd;
    logic                   reg_write;
    fu_type_e               fu_type;
    alu_op_e                alu_op;
    logic [`OOO_XLEN-1:0]   imm;
  } dec_uop_t;

  // Rename -> dispatch payload
  typedef struct packed {
    logic [`OOO_PC_W-1:0]   pc;
    logic [`OOO_PREG_W-1:0] prs1;
    logic [`OOO_PREG_W-1:0] prs2;
    logic [`OOO_PREG_W-1:0] prd;
    logic [`OOO_PREG_W-1:0] old_prd;
    logic                   has_dest;
    fu_type_e               fu_type;
    alu_op_e                alu_op;
    logic [`OOO_XLEN-1:0]   imm;
  } ren_uop_t;

endpackage

//--- ooo_stage_if.sv
`timescale 1ns/1ps
`include "ooo_defs.svh"

// --------------------
// Decode -> rename
// --------------------
interface dec_if;
  logic                   valid;
  logic                   ready;
  logic [`OOO_PC_W-1:0]   pc;
  logic [`OOO_AREG_W-1:0] rs1;
  logic [`OOO_AREG_W-1:0] rs2;
  logic [`OOO_AREG_W-1:0] rd;
  logic                   reg_write;
  ooo_pkg::fu_type_e      fu_type;
  ooo_pkg::alu_op_e       alu_op;
  logic [`OOO_XLEN-1:0]   imm;

  // Producer side, decode
  modport src (output valid, pc, rs1, rs2, rd, reg_write, fu_type, alu_op, imm,
               input  ready);
  // Consumer side, rename
  modport dst (input  valid, pc, rs1, rs2, rd, reg_write, fu_type, alu_op, imm,
               output ready);
endinterface

// --------------------
// Rename -> dispatch
// --------------------
interface ren_if;
  logic                   valid;
  logic                   ready;
  logic [`OOO_PC_W-1:0]   pc;
  logic [`OOO_PREG_W-1:0] prs1;
  logic [`OOO_PREG_W-1:0] prs2;
  logic [`OOO_PREG_W-1:0] prd;
  logic [`OOO_PREG_W-1:0] old_prd;
  logic                   has_dest;
  ooo_pkg::fu_type_e      fu_type;
  ooo_pkg::alu_op_e       alu_op;
  logic [`OOO_XLEN-1:0]   imm;

  modport src (output valid, pc, prs1, prs2, prd, old_prd, has_dest, fu_type, alu_op, imm,
               input  ready);
  modport dst (input  valid, pc, prs1, prs2, prd, old_prd, has_dest, fu_type, alu_op, imm,
               output ready);
endinterface

//--- skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
  parameter type T = logic [31:0]
) (
  input  logic i_clk,
  input  logic i_arst_n,
  // Upstream
  input  logic i_valid,
  output logic o_ready,
  input  T     i_data,
  // Downstream
  output logic o_valid,
  input  logic i_ready,
  output T     o_data
);

  logic main_valid;
  logic spill_valid;
  T     main_data;
  T     spill_data;
  logic in_fire;
  logic out_fire;

  // Ready only depends on local state, cuts the ready path
  assign o_ready  = !spill_valid;
  assign o_valid  = main_valid;
  assign o_data   = main_data;
  assign in_fire  = i_valid && o_ready;
  assign out_fire = main_valid && i_ready;

  // Occupancy
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      main_valid  <= 1'b0;
      spill_valid <= 1'b0;
    end else if (spill_valid) begin
      // Full, spill moves up once main drains
      if (out_fire) begin
        spill_valid <= 1'b0;
      end
    end else if (in_fire) begin
      main_valid <= 1'b1;
      // Main still held downstream
      if (main_valid && !out_fire) begin
        spill_valid <= 1'b1;
      end
    end else if (out_fire) begin
      main_valid <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge i_clk) begin
    if (spill_valid) begin
      if (out_fire) begin
        main_data <= spill_data;
      end
    end else if (in_fire) begin
      if (!main_valid || out_fire) begin
        main_data <= i_data;
      end else begin
        spill_data <= i_data;
      end
    end
  end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps
`include "ooo_defs.svh"

module decode_stage (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_valid,
  output logic                 o_ready,
  input  logic [31:0]          i_instr,
  input  logic [`OOO_PC_W-1:0] i_pc,
  dec_if.src                   o_dec
);

  ooo_pkg::opcode_e     opcode;
  logic [`OOO_XLEN-1:0] imm_i;
  logic [`OOO_XLEN-1:0] imm_s;
  logic [`OOO_XLEN-1:0] imm_b;
  ooo_pkg::dec_uop_t    dec_uop;
  ooo_pkg::dec_uop_t    skid_uop;

  assign opcode = ooo_pkg::opcode_e'(i_instr[6:0]);

  // --------------------
  // Immediates
  // --------------------
  // I type, loads and ALU immediates
  assign imm_i = {{(`OOO_XLEN-12){i_instr[31]}}, i_instr[31:20]};
  // S type, split across funct7 and rd slots
  assign imm_s = {{(`OOO_XLEN-12){i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  // B type, halfword offset
  assign imm_b = {{(`OOO_XLEN-13){i_instr[31]}}, i_instr[31], i_instr[7],
                  i_instr[30:25], i_instr[11:8], 1'b0};

  // --------------------
  // Field decode
  // --------------------
  always_comb begin
    dec_uop.pc        = i_pc;
    dec_uop.rs1       = i_instr[19:15];
    dec_uop.rs2       = i_instr[24:20];
    dec_uop.rd        = i_instr[11:7];
    // Unknown opcode stays a harmless ALU op
    dec_uop.reg_write = 1'b0;
    dec_uop.fu_type   = ooo_pkg::FU_ALU;
    dec_uop.alu_op    = ooo_pkg::ALUOP_FUNCT;
    dec_uop.imm       = '0;
    case (opcode)
      ooo_pkg::OPC_OP: begin
        dec_uop.reg_write = 1'b1;
      end
      ooo_pkg::OPC_OP_IMM: begin
        dec_uop.reg_write = 1'b1;
        dec_uop.alu_op    = ooo_pkg::ALUOP_IMM;
        dec_uop.imm       = imm_i;
      end
      ooo_pkg::OPC_LOAD: begin
        dec_uop.reg_write = 1'b1;
        dec_uop.fu_type   = ooo_pkg::FU_LSU;
        dec_uop.alu_op    = ooo_pkg::ALUOP_ADD;
        dec_uop.imm       = imm_i;
      end
      ooo_pkg::OPC_STORE: begin
        dec_uop.fu_type = ooo_pkg::FU_LSU;
        dec_uop.alu_op  = ooo_pkg::ALUOP_ADD;
        dec_uop.imm     = imm_s;
      end
      ooo_pkg::OPC_BRANCH: begin
        dec_uop.fu_type = ooo_pkg::FU_BRANCH;
        dec_uop.alu_op  = ooo_pkg::ALUOP_BRANCH;
        dec_uop.imm     = imm_b;
      end
      default: begin
        dec_uop.reg_write = 1'b0;
      end
    endcase
  end

  // Pipeline register towards rename
  skid_buffer #(.T(ooo_pkg::dec_uop_t)) u_skid (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_valid),
    .o_ready  (o_ready),
    .i_data   (dec_uop),
    .o_valid  (o_dec.valid),
    .i_ready  (o_dec.ready),
    .o_data   (skid_uop)
  );

  // Unpack onto the stage interface
  assign o_dec.pc        = skid_uop.pc;
  assign o_dec.rs1       = skid_uop.rs1;
  assign o_dec.rs2       = skid_uop.rs2;
  assign o_dec.rd        = skid_uop.rd;
  assign o_dec.reg_write = skid_uop.reg_write;
  assign o_dec.fu_type   = skid_uop.fu_type;
  assign o_dec.alu_op    = skid_uop.alu_op;
  assign o_dec.imm       = skid_uop.imm;

endmodule

//--- rename_stage.sv
`timescale 1ns/1ps
`include "ooo_defs.svh"

module rename_stage (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  dec_if.dst                     i_dec,
  ren_if.src                     o_ren,
  // Freed register from commit
  input  logic                   i_free_valid,
  input  logic [`OOO_PREG_W-1:0] i_free_preg
);

  localparam int ARCH_REGS = 1 << `OOO_AREG_W;
  localparam int PREG_BITS = `OOO_PREG_W;
  // Registers not mapped at reset
  localparam int FREE_INIT = `OOO_NUM_PREGS - ARCH_REGS;

  logic [`OOO_PREG_W-1:0] rat     [ARCH_REGS];
  logic [`OOO_PREG_W-1:0] fl_mem  [`OOO_NUM_PREGS];
  logic [`OOO_PREG_W-1:0] fl_head;
  logic [`OOO_PREG_W-1:0] fl_tail;
  logic [`OOO_PREG_W:0]   fl_count;
  logic                   fl_empty;
  logic                   alloc;
  logic                   stall;
  logic                   skid_ready;
  logic                   fire;
  logic                   pop;
  ooo_pkg::ren_uop_t      ren_uop;
  ooo_pkg::ren_uop_t      skid_uop;

  // --------------------
  // Handshake
  // --------------------
  // x0 writes never take a register
  assign alloc    = i_dec.reg_write && (i_dec.rd != '0);
  assign fl_empty = (fl_count == '0);
  assign stall    = alloc && fl_empty;
  assign i_dec.ready = skid_ready && !stall;
  assign fire     = i_dec.valid && i_dec.ready;
  assign pop      = fire && alloc;

  // Lookup, one instruction per cycle so no intra-cycle bypass
  always_comb begin
    ren_uop.pc       = i_dec.pc;
    ren_uop.prs1     = rat[i_dec.rs1];
    ren_uop.prs2     = rat[i_dec.rs2];
    ren_uop.prd      = alloc ? fl_mem[fl_head] : '0;
    ren_uop.old_prd  = alloc ? rat[i_dec.rd] : '0;
    ren_uop.has_dest = alloc;
    ren_uop.fu_type  = i_dec.fu_type;
    ren_uop.alu_op   = i_dec.alu_op;
    ren_uop.imm      = i_dec.imm;
  end

  // --------------------
  // Alias table
  // --------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      // Identity map
      for (int i = 0; i < ARCH_REGS; i++) begin
        rat[i] <= PREG_BITS'(i);
      end
    end else if (pop) begin
      rat[i_dec.rd] <= fl_mem[fl_head];
    end
  end

  // --------------------
  // Free list FIFO
  // --------------------
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      // p32..p127 in ascending order
      for (int i = 0; i < FREE_INIT; i++) begin
        fl_mem[i] <= PREG_BITS'(i + ARCH_REGS);
      end
      fl_head  <= '0;
      fl_tail  <= PREG_BITS'(FREE_INIT);
      fl_count <= (PREG_BITS + 1)'(FREE_INIT);
    end else begin
      if (pop) begin
        fl_head <= fl_head + 1'b1;
      end
      if (i_free_valid) begin
        fl_mem[fl_tail] <= i_free_preg;
        fl_tail         <= fl_tail + 1'b1;
      end
      case ({i_free_valid, pop})
        2'b10:   fl_count <= fl_count + 1'b1;
        2'b01:   fl_count <= fl_count - 1'b1;
        default: fl_count <= fl_count;
      endcase
    end
  end

  // Pipeline register towards dispatch
  skid_buffer #(.T(ooo_pkg::ren_uop_t)) u_skid (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_dec.valid && !stall),
    .o_ready  (skid_ready),
    .i_data   (ren_uop),
    .o_valid  (o_ren.valid),
    .i_ready  (o_ren.ready),
    .o_data   (skid_uop)
  );

  assign o_ren.pc       = skid_uop.pc;
  assign o_ren.prs1     = skid_uop.prs1;
  assign o_ren.prs2     = skid_uop.prs2;
  assign o_ren.prd      = skid_uop.prd;
  assign o_ren.old_prd  = skid_uop.old_prd;
  assign o_ren.has_dest = skid_uop.has_dest;
  assign o_ren.fu_type  = skid_uop.fu_type;
  assign o_ren.alu_op   = skid_uop.alu_op;
  assign o_ren.imm      = skid_uop.imm;

endmodule

//--- dispatch_stage.sv
`timescale 1ns/1ps
`include "ooo_defs.svh"

module dispatch_stage (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  ren_if.dst                     i_ren,
  // Issue port
  output logic                   o_issue_valid,
  input  logic                   i_issue_ready,
  output logic [`OOO_ROB_W-1:0]  o_issue_tag,
  output ooo_pkg::fu_type_e      o_issue_fu_type,
  output ooo_pkg::alu_op_e       o_issue_alu_op,
  output logic [`OOO_PREG_W-1:0] o_issue_prs1,
  output logic [`OOO_PREG_W-1:0] o_issue_prs2,
  output logic [`OOO_PREG_W-1:0] o_issue_prd,
  output logic [`OOO_XLEN-1:0]   o_issue_imm,
  output logic [`OOO_PC_W-1:0]   o_issue_pc,
  // Writeback strobe
  input  logic                   i_wb_valid,
  input  logic [`OOO_ROB_W-1:0]  i_wb_tag,
  // Commit and register release
  output logic                   o_commit_valid,
  output logic [`OOO_ROB_W-1:0]  o_commit_tag,
  output logic [`OOO_PREG_W-1:0] o_commit_old_prd,
  output logic                   o_free_valid,
  output logic [`OOO_PREG_W-1:0] o_free_preg
);

  logic                   rob_done     [`OOO_ROB_DEPTH];
  logic                   rob_has_dest [`OOO_ROB_DEPTH];
  logic [`OOO_PREG_W-1:0] rob_old_prd  [`OOO_ROB_DEPTH];
  logic [`OOO_ROB_W-1:0]  rob_head;
  logic [`OOO_ROB_W-1:0]  rob_tail;
  logic [`OOO_ROB_W:0]    rob_count;
  logic                   rob_full;
  logic                   issue_fire;

  // --------------------
  // Issue
  // --------------------
  assign rob_full      = (rob_count == `OOO_ROB_DEPTH);
  assign o_issue_valid = i_ren.valid && !rob_full;
  assign i_ren.ready   = i_issue_ready && !rob_full;
  assign issue_fire    = o_issue_valid && i_issue_ready;

  // Tag is the ROB slot being allocated
  assign o_issue_tag     = rob_tail;
  assign o_issue_fu_type = i_ren.fu_type;
  assign o_issue_alu_op  = i_ren.alu_op;
  assign o_issue_prs1    = i_ren.prs1;
  assign o_issue_prs2    = i_ren.prs2;
  assign o_issue_prd     = i_ren.prd;
  assign o_issue_imm     = i_ren.imm;
  assign o_issue_pc      = i_ren.pc;

  // --------------------
  // Commit, in order from head
  // --------------------
  assign o_commit_valid   = (rob_count != '0) && rob_done[rob_head];
  assign o_commit_tag     = rob_head;
  assign o_commit_old_prd = rob_old_prd[rob_head];
  // Only entries that renamed a destination give a register back
  assign o_free_valid     = o_commit_valid && rob_has_dest[rob_head];
  assign o_free_preg      = rob_old_prd[rob_head];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rob_head  <= '0;
      rob_tail  <= '0;
      rob_count <= '0;
      for (int i = 0; i < `OOO_ROB_DEPTH; i++) begin
        rob_done[i] <= 1'b0;
      end
    end else begin
      if (issue_fire) begin
        rob_done[rob_tail] <= 1'b0;
        rob_tail           <= rob_tail + 1'b1;
      end
      if (o_commit_valid) begin
        rob_done[rob_head] <= 1'b0;
        rob_head           <= rob_head + 1'b1;
      end
      // Done mark, commit follows next cycle at the earliest
      if (i_wb_valid) begin
        rob_done[i_wb_tag] <= 1'b1;
      end
      case ({issue_fire, o_commit_valid})
        2'b10:   rob_count <= rob_count + 1'b1;
        2'b01:   rob_count <= rob_count - 1'b1;
        default: rob_count <= rob_count;
      endcase
    end
  end

  // Entry payload written at allocation
  always_ff @(posedge i_clk) begin
    if (issue_fire) begin
      rob_has_dest[rob_tail] <= i_ren.has_dest;
      rob_old_prd[rob_tail]  <= i_ren.old_prd;
    end
  end

endmodule

//--- ooo_frontend.sv
`timescale 1ns/1ps
`include "ooo_defs.svh"

module ooo_frontend (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  // Instruction stream in
  input  logic                   i_instr_valid,
  output logic                   o_instr_ready,
  input  logic [31:0]            i_instr,
  input  logic [`OOO_PC_W-1:0]   i_pc,
  // Issue
  output logic                   o_issue_valid,
  input  logic                   i_issue_ready,
  output logic [`OOO_ROB_W-1:0]  o_issue_tag,
  output ooo_pkg::fu_type_e      o_issue_fu_type,
  output ooo_pkg::alu_op_e       o_issue_alu_op,
  output logic [`OOO_PREG_W-1:0] o_issue_prs1,
  output logic [`OOO_PREG_W-1:0] o_issue_prs2,
  output logic [`OOO_PREG_W-1:0] o_issue_prd,
  output logic [`OOO_XLEN-1:0]   o_issue_imm,
  output logic [`OOO_PC_W-1:0]   o_issue_pc,
  // Writeback
  input  logic                   i_wb_valid,
  input  logic [`OOO_ROB_W-1:0]  i_wb_tag,
  // Commit
  output logic                   o_commit_valid,
  output logic [`OOO_ROB_W-1:0]  o_commit_tag,
  output logic [`OOO_PREG_W-1:0] o_commit_old_prd
);

  // Released register loop, dispatch back to rename
  logic                   free_valid;
  logic [`OOO_PREG_W-1:0] free_preg;

  dec_if u_dec_if ();
  ren_if u_ren_if ();

  // --------------------
  // Stages
  // --------------------
  decode_stage u_decode (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_instr_valid),
    .o_ready  (o_instr_ready),
    .i_instr  (i_instr),
    .i_pc     (i_pc),
    .o_dec    (u_dec_if.src)
  );

  rename_stage u_rename (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_dec        (u_dec_if.dst),
    .o_ren        (u_ren_if.src),
    .i_free_valid (free_valid),
    .i_free_preg  (free_preg)
  );

  dispatch_stage u_dispatch (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_ren            (u_ren_if.dst),
    .o_issue_valid    (o_issue_valid),
    .i_issue_ready    (i_issue_ready),
    .o_issue_tag      (o_issue_tag),
    .o_issue_fu_type  (o_issue_fu_type),
    .o_issue_alu_op   (o_issue_alu_op),
    .o_issue_prs1     (o_issue_prs1),
    .o_issue_prs2     (o_issue_prs2),
    .o_issue_prd      (o_issue_prd),
    .o_issue_imm      (o_issue_imm),
    .o_issue_pc       (o_issue_pc),
    .i_wb_valid       (i_wb_valid),
    .i_wb_tag         (i_wb_tag),
    .o_commit_valid   (o_commit_valid),
    .o_commit_tag     (o_commit_tag),
    .o_commit_old_prd (o_commit_old_prd),
    .o_free_valid     (free_valid),
    .o_free_preg      (free_preg)
  );

endmodule

//--- tb_ooo_frontend.sv
`timescale 1ns/1ps
`include "ooo_defs.svh"

module tb_ooo_frontend;

  // Expected view of one instruction sent into the pipe
  typedef struct {
    logic [`OOO_PC_W-1:0]   pc;
    logic [`OOO_AREG_W-1:0] rs1;
    logic [`OOO_AREG_W-1:0] rs2;
    logic [`OOO_AREG_W-1:0] rd;
    logic                   rw;
    logic [1:0]             fu;
    logic [1:0]             aluop;
    logic [`OOO_XLEN-1:0]   imm;
  } exp_t;

  // ROB model entry
  typedef struct {
    logic [`OOO_ROB_W-1:0]  tag;
    logic                   has_dest;
    logic [`OOO_PREG_W-1:0] old_prd;
  } rob_t;

  localparam int TIMEOUT = 200;

  logic                   i_clk;
  logic                   i_arst_n;
  logic                   i_instr_valid;
  logic                   o_instr_ready;
  logic [31:0]            i_instr;
  logic [`OOO_PC_W-1:0]   i_pc;
  logic                   o_issue_valid;
  logic                   i_issue_ready;
  logic [`OOO_ROB_W-1:0]  o_issue_tag;
  ooo_pkg::fu_type_e      o_issue_fu_type;
  ooo_pkg::alu_op_e       o_issue_alu_op;
  logic [`OOO_PREG_W-1:0] o_issue_prs1;
  logic [`OOO_PREG_W-1:0] o_issue_prs2;
  logic [`OOO_PREG_W-1:0] o_issue_prd;
  logic [`OOO_XLEN-1:0]   o_issue_imm;
  logic [`OOO_PC_W-1:0]   o_issue_pc;
  logic                   i_wb_valid;
  logic [`OOO_ROB_W-1:0]  i_wb_tag;
  logic                   o_commit_valid;
  logic [`OOO_ROB_W-1:0]  o_commit_tag;
  logic [`OOO_PREG_W-1:0] o_commit_old_prd;

  // --------------------
  // Reference model state
  // --------------------
  logic [`OOO_PREG_W-1:0] rat [32];
  logic [`OOO_PREG_W-1:0] free_q [$];
  exp_t                   pend_q [$];
  rob_t                   rob_q [$];
  logic [`OOO_ROB_W-1:0]  wb_q [$];
  logic [`OOO_ROB_W-1:0]  next_tag;
  logic [`OOO_PC_W-1:0]   next_pc;
  integer                 seed;
  int                     errors;
  int                     checks;
  int                     issued;
  int                     committed;
  int                     alloc_cnt;
  int                     test_err_base;

  ooo_frontend u_ooo_frontend (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_instr_valid    (i_instr_valid),
    .o_instr_ready    (o_instr_ready),
    .i_instr          (i_instr),
    .i_pc             (i_pc),
    .o_issue_valid    (o_issue_valid),
    .i_issue_ready    (i_issue_ready),
    .o_issue_tag      (o_issue_tag),
    .o_issue_fu_type  (o_issue_fu_type),
    .o_issue_alu_op   (o_issue_alu_op),
    .o_issue_prs1     (o_issue_prs1),
    .o_issue_prs2     (o_issue_prs2),
    .o_issue_prd      (o_issue_prd),
    .o_issue_imm      (o_issue_imm),
    .o_issue_pc       (o_issue_pc),
    .i_wb_valid       (i_wb_valid),
    .i_wb_tag         (i_wb_tag),
    .o_commit_valid   (o_commit_valid),
    .o_commit_tag     (o_commit_tag),
    .o_commit_old_prd (o_commit_old_prd)
  );

  // 10 ns clock
  always #5 i_clk = ~i_clk;

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic abort_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("TEST FAILED");
    $finish;
  endtask

  // --------------------
  // Monitor sampled mid-cycle
  // --------------------
  always @(negedge i_clk) begin
    exp_t                   e;
    rob_t                   r;
    logic                   alloc;
    logic [`OOO_PREG_W-1:0] p;
    if (i_arst_n && o_issue_valid && i_issue_ready) begin
      if (pend_q.size() == 0) begin
        errors++;
        $display("Issue seen at t=%0t with no instruction outstanding", $time);
      end else begin
        e = pend_q.pop_front();
        check_val("o_issue_pc", 32'(o_issue_pc), 32'(e.pc));
        check_val("o_issue_tag", 32'(o_issue_tag), 32'(next_tag));
        check_val("o_issue_fu_type", 32'(o_issue_fu_type), 32'(e.fu));
        check_val("o_issue_alu_op", 32'(o_issue_alu_op), 32'(e.aluop));
        check_val("o_issue_imm", o_issue_imm, e.imm);
        check_val("o_issue_prs1", 32'(o_issue_prs1), 32'(rat[e.rs1]));
        check_val("o_issue_prs2", 32'(o_issue_prs2), 32'(rat[e.rs2]));
        // x0 and non-writing instructions take no register
        alloc = e.rw && (e.rd != 0);
        r.tag      = next_tag;
        r.has_dest = alloc;
        r.old_prd  = '0;
        if (alloc) begin
          if (free_q.size() == 0) begin
            errors++;
            $display("Model free list empty at t=%0t", $time);
          end else begin
            p = free_q.pop_front();
            check_val("o_issue_prd", 32'(o_issue_prd), 32'(p));
            r.old_prd = rat[e.rd];
            rat[e.rd] = p;
            alloc_cnt++;
          end
        end else begin
          check_val("o_issue_prd", 32'(o_issue_prd), 32'd0);
        end
        rob_q.push_back(r);
        wb_q.push_back(next_tag);
        next_tag = next_tag + 1'b1;
        issued++;
      end
    end
    if (i_arst_n && o_commit_valid) begin
      if (rob_q.size() == 0) begin
        errors++;
        $display("Commit seen at t=%0t with an empty ROB model", $time);
      end else begin
        r = rob_q.pop_front();
        check_val("o_commit_tag", 32'(o_commit_tag), 32'(r.tag));
        check_val("o_commit_old_prd", 32'(o_commit_old_prd), 32'(r.old_prd));
        // Freed register goes to the back of the free list
        if (r.has_dest) begin
          free_q.push_back(r.old_prd);
        end
        committed++;
      end
    end
  end

  // --------------------
  // Drivers
  // --------------------
  // kind 0 OP, 1 OP_IMM, 2 LOAD, 3 STORE, 4 BRANCH
  task automatic send_instr(input int kind, input logic [4:0] rs1, input logic [4:0] rs2,
                            input logic [4:0] rd, input logic [12:0] imm);
    exp_t        e;
    logic [31:0] w;
    int          n;
    e.pc    = next_pc;
    e.rs1   = rs1;
    e.rs2   = rs2;
    e.rd    = rd;
    e.rw    = 1'b0;
    e.fu    = ooo_pkg::FU_ALU;
    e.aluop = ooo_pkg::ALUOP_FUNCT;
    e.imm   = '0;
    case (kind)
      0: begin
        w    = {7'd0, rs2, rs1, 3'd0, rd, 7'b0110011};
        e.rw = 1'b1;
      end
      1: begin
        w       = {imm[11:0], rs1, 3'd0, rd, 7'b0010011};
        e.rw    = 1'b1;
        e.aluop = ooo_pkg::ALUOP_IMM;
        e.imm   = {{20{imm[11]}}, imm[11:0]};
        // rs2 slot holds immediate bits
        e.rs2   = imm[4:0];
      end
      2: begin
        w       = {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
        e.rw    = 1'b1;
        e.fu    = ooo_pkg::FU_LSU;
        e.aluop = ooo_pkg::ALUOP_ADD;
        e.imm   = {{20{imm[11]}}, imm[11:0]};
        e.rs2   = imm[4:0];
      end
      3: begin
        w       = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
        e.fu    = ooo_pkg::FU_LSU;
        e.aluop = ooo_pkg::ALUOP_ADD;
        e.imm   = {{20{imm[11]}}, imm[11:0]};
        e.rd    = imm[4:0];
      end
      default: begin
        // Branch offset is even
        w       = {imm[12], imm[10:5], rs2, rs1, 3'd0, imm[4:1], imm[11], 7'b1100011};
        e.fu    = ooo_pkg::FU_BRANCH;
        e.aluop = ooo_pkg::ALUOP_BRANCH;
        e.imm   = {{19{imm[12]}}, imm[12:1], 1'b0};
        e.rd    = {imm[4:1], imm[11]};
      end
    endcase
    pend_q.push_back(e);
    @(posedge i_clk);
    i_instr_valid <= 1'b1;
    i_instr       <= w;
    i_pc          <= next_pc;
    next_pc = next_pc + 4;
    n = 0;
    while (1) begin
      @(negedge i_clk);
      if (o_instr_ready) break;
      n++;
      if (n > TIMEOUT) abort_timeout("o_instr_ready");
    end
    @(posedge i_clk);
    i_instr_valid <= 1'b0;
  endtask

  task automatic send_rand_op(input bit nonzero_rd);
    logic [4:0] rd;
    rd = 5'($random(seed));
    if (nonzero_rd && rd == 0) rd = 5'd1;
    send_instr(0, 5'($random(seed)), 5'($random(seed)), rd, 13'd0);
  endtask

  task automatic writeback(input logic [`OOO_ROB_W-1:0] tag);
    @(posedge i_clk);
    i_wb_valid <= 1'b1;
    i_wb_tag   <= tag;
    @(posedge i_clk);
    i_wb_valid <= 1'b0;
  endtask

  task automatic wait_issued(input int target);
    int n;
    n = 0;
    while (issued < target) begin
      @(negedge i_clk);
      n++;
      if (n > TIMEOUT) abort_timeout("instructions to issue");
    end
  endtask

  // Write back everything outstanding in order and wait for the commits
  task automatic drain_rob();
    int n;
    while (wb_q.size() > 0) begin
      writeback(wb_q.pop_front());
    end
    n = 0;
    while (committed < issued) begin
      @(negedge i_clk);
      n++;
      if (n > TIMEOUT) abort_timeout("commits");
    end
  endtask

  task automatic end_test(input string name);
    $display("%s finished with %0d errors", name, errors - test_err_base);
    test_err_base = errors;
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic reset_values();
    check_val("o_instr_ready", 32'(o_instr_ready), 32'd1);
    check_val("o_issue_valid", 32'(o_issue_valid), 32'd0);
    check_val("o_commit_valid", 32'(o_commit_valid), 32'd0);
    end_test("reset");
  endtask

  task automatic rename_sequence();
    int base;
    base = issued;
    for (int i = 0; i < 12; i++) begin
      send_rand_op(1'b0);
    end
    // Explicit x0 destination
    send_instr(0, 5'd3, 5'd4, 5'd0, 13'd0);
    wait_issued(base + 13);
    drain_rob();
    end_test("rename");
  endtask

  task automatic decode_formats();
    int base;
    base = issued;
    send_instr(2, 5'd5, 5'd0, 5'd6, 13'h0ff0);
    send_instr(2, 5'd7, 5'd0, 5'd8, 13'h0123);
    send_instr(3, 5'd9, 5'd10, 5'd0, 13'h0801);
    send_instr(3, 5'd11, 5'd12, 5'd0, 13'h07fe);
    send_instr(4, 5'd1, 5'd2, 5'd0, 13'h1ffc);
    send_instr(4, 5'd3, 5'd4, 5'd0, 13'h0ffe);
    send_instr(0, 5'd13, 5'd14, 5'd15, 13'd0);
    send_instr(1, 5'd16, 5'd0, 5'd17, 13'h0800);
    send_instr(1, 5'd18, 5'd0, 5'd19, 13'h007f);
    wait_issued(base + 9);
    drain_rob();
    end_test("decode");
  endtask

  task automatic backpressure_burst();
    int base;
    base = issued;
    @(posedge i_clk);
    i_issue_ready <= 1'b0;
    // Two skid buffers of two entries each
    for (int i = 0; i < 4; i++) begin
      send_rand_op(1'b1);
    end
    repeat (3) @(negedge i_clk);
    check_val("o_instr_ready", 32'(o_instr_ready), 32'd0);
    // Oldest of the burst waits at the issue port
    check_val("o_issue_valid", 32'(o_issue_valid), 32'd1);
    check_val("o_issue_pc", 32'(o_issue_pc), 32'(pend_q[0].pc));
    fork
      send_rand_op(1'b1);
      begin
        repeat (4) @(posedge i_clk);
        i_issue_ready <= 1'b1;
      end
    join
    for (int i = 0; i < 5; i++) begin
      send_rand_op(1'b1);
    end
    wait_issued(base + 10);
    repeat (5) @(negedge i_clk);
    check_val("issue count", 32'(issued), 32'(base + 10));
    drain_rob();
    end_test("backpressure");
  endtask

  task automatic rob_full_commit();
    int base;
    base = issued;
    for (int i = 0; i < 16; i++) begin
      send_rand_op(1'b0);
    end
    wait_issued(base + 16);
    // One more must stay blocked by the full ROB
    send_rand_op(1'b1);
    repeat (10) @(negedge i_clk);
    check_val("issued with full ROB", 32'(issued), 32'(base + 16));
    check_val("o_issue_valid", 32'(o_issue_valid), 32'd0);
    check_val("o_commit_valid", 32'(o_commit_valid), 32'd0);
    // Writebacks in reverse order still commit in tag order
    while (wb_q.size() > 0) begin
      writeback(wb_q.pop_back());
    end
    wait_issued(base + 17);
    drain_rob();
    end_test("rob_commit");
  endtask

  task automatic freelist_recycle();
    for (int b = 0; b < 8; b++) begin
      for (int i = 0; i < 16; i++) begin
        send_rand_op(1'b1);
      end
      wait_issued(issued + 16 - (issued - committed));
      drain_rob();
    end
    check_val("allocations beyond initial pool", 32'(alloc_cnt > 96), 32'd1);
    end_test("recycle");
  endtask

  initial begin
    i_clk         = 1'b0;
    i_arst_n      = 1'b0;
    i_instr_valid = 1'b0;
    i_instr       = '0;
    i_pc          = '0;
    i_issue_ready = 1'b1;
    i_wb_valid    = 1'b0;
    i_wb_tag      = '0;
    seed          = 32'h83db_b261;
    errors        = 0;
    checks        = 0;
    issued        = 0;
    committed     = 0;
    alloc_cnt     = 0;
    test_err_base = 0;
    next_tag      = '0;
    next_pc       = '0;
    // Model reset to the identity map with p32..p127 free
    for (int i = 0; i < 32; i++) begin
      rat[i] = 7'(i);
    end
    for (int i = 32; i < `OOO_NUM_PREGS; i++) begin
      free_q.push_back(7'(i));
    end
    repeat (8) @(posedge i_clk);
    i_arst_n <= 1'b1;
    @(negedge i_clk);
    reset_values();
    rename_sequence();
    decode_formats();
    backpressure_burst();
    rob_full_commit();
    freelist_recycle();
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+.
ooo_pkg.sv
ooo_stage_if.sv
skid_buffer.sv
decode_stage.sv
rename_stage.sv
dispatch_stage.sv
ooo_frontend.sv
tb_ooo_frontend.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ooo_frontend
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
